// ==== dv/lim_cases.txt ====
// columns: kind addr data be expected, all hex
// kind 0 store, 1 load, 2 program, 3 fetch, 4 back-to-back load, f end
0 010 a5a5f00d f 00000000
1 010 00000000 f a5a5f00d
3 010 00000000 0 a5a5f00d
0 010 11223344 5 00000000
1 010 00000000 f a522f044
0 014 deadbeef f 00000000
0 014 00cafe00 6 00000000
1 014 00000000 f decafeef
// load with logic op, stored word unchanged
0 020 0f0f3c3c f 00000000
2 ffc 00000101 f 00000000
1 020 ff00ff00 f 0f003c00
2 ffc 00000106 f 00000000
1 020 00ff00ff f f00fc33c
2 ffc 00000000 f 00000000
1 020 00000000 f 0f0f3c3c
// store with each logic op, checked over port a
0 030 12345678 f 00000000
2 ffc 00000101 f 00000000
0 030 f0f0ff00 f 00000000
3 030 00000000 0 10305600
2 ffc 00000102 f 00000000
0 030 0000000f f 00000000
3 030 00000000 0 1030560f
2 ffc 00000103 f 00000000
0 030 ffff0000 f 00000000
3 030 00000000 0 efcf560f
2 ffc 00000104 f 00000000
0 030 ff00ff00 f 00000000
3 030 00000000 0 10ffa9ff
2 ffc 00000105 f 00000000
0 030 00000f0f f 00000000
3 030 00000000 0 ef005000
2 ffc 00000106 f 00000000
0 030 0f0f0f0f f 00000000
3 030 00000000 0 1ff0a0f0
0 030 00000000 1 00000000
3 030 00000000 0 1ff0a00f
2 ffc 00000000 f 00000000
1 030 00000000 f 1ff0a00f
// xor over four words from 0x100
0 0fc 0badf00d f 00000000
0 100 00000001 f 00000000
0 104 00000002 f 00000000
0 108 00000003 f 00000000
0 10c 00000004 f 00000000
0 110 00000005 f 00000000
2 ffc 00000403 f 00000000
0 100 ffff0000 f 00000000
2 ffc 00000000 f 00000000
1 0fc 00000000 f 0badf00d
1 100 00000000 f ffff0001
1 104 00000000 f ffff0002
1 108 00000000 f ffff0003
1 10c 00000000 f ffff0004
1 110 00000000 f 00000005
// cell readback, then back-to-back loads under or
2 ffc 00000a02 f 00000000
1 ffc 00000000 f 00000a02
4 010 0000000f f a522f04f
4 014 00000000 f decafeef
4 ffc 00000000 f 00000a02
4 030 f0000000 f fff0a00f
4 100 00000000 f ffff0001
2 ffc 00000000 f 00000000
f 000 00000000 0 00000000

// ==== src.f ====
hdl/lim_pkg.sv
hdl/lim_row_if.sv
hdl/lim_func_cell.sv
hdl/lim_row_decoder.sv
hdl/lim_array.sv
hdl/lim_ram_top.sv
dv/tb_clk_gen.sv
dv/tb_lim_ram.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the lim ram testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_lim_ram -f src.f -o tb_lim_ram
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_lim_ram > sim.log 2>&1
status=$?
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    echo "simulation reported failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

exit 0

// ==== dv/tb_lim_ram.sv ====
// logic-in-memory ram testbench
`default_nettype none

module tb_lim_ram import lim_pkg::*; ();

    localparam int MAX_CASES   = 96;
    localparam int FIELDS      = 5;     // kind, addr, data, be, expected
    localparam int WAIT_CYCLES = 16;    // per response
    localparam int RUN_CYCLES  = 5000;  // whole run

    localparam logic [31:0] K_STORE   = 32'h0;
    localparam logic [31:0] K_LOAD    = 32'h1;
    localparam logic [31:0] K_PROGRAM = 32'h2;
    localparam logic [31:0] K_FETCH   = 32'h3;
    localparam logic [31:0] K_BURST   = 32'h4;  // load right after the previous one
    localparam logic [31:0] K_END     = 32'hf;

    logic                  clk;
    logic                  rst_n;
    logic                  en_a;
    logic [ADDR_WIDTH-1:0] addr_a;
    logic [DATA_WIDTH-1:0] rdata_a;
    logic                  en_b;
    logic                  we_b;
    logic [ADDR_WIDTH-1:0] addr_b;
    logic [DATA_WIDTH-1:0] wdata_b;
    logic [3:0]            be_b;
    logic [DATA_WIDTH-1:0] rdata_b;
    logic                  rvalid_b;

    logic [31:0] case_mem [FIELDS*MAX_CASES];

    tb_clk_gen u_clk_gen (
        .clk_o (clk)
    );

    lim_ram_top DUT (
        .clk_i      (clk),
        .rst_ni     (rst_n),
        .en_a_i     (en_a),
        .addr_a_i   (addr_a),
        .rdata_a_o  (rdata_a),
        .en_b_i     (en_b),
        .we_b_i     (we_b),
        .addr_b_i   (addr_b),
        .wdata_b_i  (wdata_b),
        .be_b_i     (be_b),
        .rdata_b_o  (rdata_b),
        .rvalid_b_o (rvalid_b)
    );

    // ========================================================================
    // helpers
    // ========================================================================

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED %s: expected %08h, actual %08h",
                                name, expected, actual));
        end
    endtask

    function automatic logic [31:0] case_field(input int idx, input int field);
        return case_mem[idx*FIELDS + field];
    endfunction

    function automatic string kind_name(input logic [31:0] kind);
        case (kind)
            K_STORE:   return "store";
            K_LOAD:    return "load";
            K_PROGRAM: return "program";
            K_FETCH:   return "fetch";
            K_BURST:   return "burst load";
            default:   return "unknown";
        endcase
    endfunction

    function automatic string case_name(input int idx);
        return $sformatf("case %0d %s @%03h", idx, kind_name(case_field(idx, 0)),
                         case_field(idx, 1) & 32'hfff);
    endfunction

    // one-cycle strobe on port b
    task automatic pulse_b_request(input logic we, input logic [ADDR_WIDTH-1:0] addr,
                                   input logic [31:0] data, input logic [3:0] be);
        @(posedge clk);
        en_b    <= 1'b1;
        we_b    <= we;
        addr_b  <= addr;
        wdata_b <= data;
        be_b    <= be;
        @(posedge clk);
        en_b    <= 1'b0;
        we_b    <= 1'b0;
    endtask

    // rvalid must come one cycle after the strobe and last one cycle
    task automatic await_response(input string name, input logic is_load,
                                  input logic [31:0] expected);
        int cycles;
        cycles = 1;
        @(negedge clk);
        while (rvalid_b !== 1'b1) begin
            if (cycles >= WAIT_CYCLES) begin
                abort_run($sformatf("%s got no rvalid within %0d cycles", name, cycles));
            end
            @(negedge clk);
            cycles++;
        end
        check_value($sformatf("%s rvalid latency", name), 32'd1, cycles);
        if (is_load) begin
            check_value(name, expected, rdata_b);
        end
        @(negedge clk);
        check_value($sformatf("%s rvalid width", name), 32'd0, 32'(rvalid_b));
    endtask

    task automatic fetch_a(input string name, input logic [ADDR_WIDTH-1:0] addr,
                           input logic [31:0] expected);
        @(posedge clk);
        en_a   <= 1'b1;
        addr_a <= addr;
        @(posedge clk);
        en_a   <= 1'b0;
        @(negedge clk);  // word shows one cycle after the strobe
        check_value(name, expected, rdata_a);
    endtask

    // strobes every cycle, response k checked while strobe k+1 is on the bus
    task automatic run_burst(input int first, input int last);
        for (int k = first; k <= last + 1; k++) begin
            @(posedge clk);
            if (k <= last) begin
                en_b    <= 1'b1;
                we_b    <= 1'b0;
                addr_b  <= ADDR_WIDTH'(case_field(k, 1));
                wdata_b <= case_field(k, 2);
                be_b    <= 4'(case_field(k, 3));
            end else begin
                en_b    <= 1'b0;
            end
            if (k > first) begin
                @(negedge clk);
                check_value($sformatf("%s rvalid", case_name(k-1)), 32'd1, 32'(rvalid_b));
                check_value(case_name(k-1), case_field(k-1, 4), rdata_b);
            end
        end
        @(negedge clk);
        check_value($sformatf("%s rvalid width", case_name(last)), 32'd0, 32'(rvalid_b));
    endtask

    // ========================================================================
    // main sequence
    // ========================================================================

    initial begin
        int          idx;
        int          last;
        logic [31:0] kind;
        for (int i = 0; i < FIELDS*MAX_CASES; i++) begin
            case_mem[i] = K_END;
        end
        $readmemh("dv/lim_cases.txt", case_mem);
        rst_n   = 1'b0;
        en_a    = 1'b0;
        addr_a  = '0;
        // cell store strobed through reset, neither rvalid nor the cell may react
        en_b    = 1'b1;
        we_b    = 1'b1;
        addr_b  = FUNCT_ADDR;
        wdata_b = 32'h0000_0203;
        be_b    = 4'hf;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        en_b  <= 1'b0;
        we_b  <= 1'b0;
        @(negedge clk);
        check_value("reset rvalid", 32'd0, 32'(rvalid_b));
        pulse_b_request(1'b0, FUNCT_ADDR, 32'd0, 4'hf);
        await_response("reset function cell", 1'b1, 32'd0);

        idx = 0;
        while (idx < MAX_CASES && case_field(idx, 0) != K_END) begin
            kind = case_field(idx, 0);
            case (kind)
                K_STORE: begin
                    pulse_b_request(1'b1, ADDR_WIDTH'(case_field(idx, 1)), case_field(idx, 2),
                                    4'(case_field(idx, 3)));
                    await_response(case_name(idx), 1'b0, 32'd0);
                end
                K_LOAD: begin
                    pulse_b_request(1'b0, ADDR_WIDTH'(case_field(idx, 1)), case_field(idx, 2),
                                    4'(case_field(idx, 3)));
                    await_response(case_name(idx), 1'b1, case_field(idx, 4));
                end
                K_PROGRAM: begin
                    pulse_b_request(1'b1, FUNCT_ADDR, case_field(idx, 2), 4'hf);
                    await_response(case_name(idx), 1'b0, 32'd0);
                end
                K_FETCH: begin
                    fetch_a(case_name(idx), ADDR_WIDTH'(case_field(idx, 1)), case_field(idx, 4));
                end
                K_BURST: begin
                    last = idx;
                    while (last + 1 < MAX_CASES && case_field(last + 1, 0) == K_BURST) begin
                        last++;
                    end
                    run_burst(idx, last);
                    idx = last;
                end
                default: begin
                    abort_run($sformatf("case %0d has an unknown kind %0h", idx, kind));
                end
            endcase
            idx++;
        end

        if (idx == 0) begin
            abort_run("no cases were read from dv/lim_cases.txt");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

    // hang guard
    initial begin
        repeat (RUN_CYCLES) @(posedge clk);
        abort_run($sformatf("run did not finish within %0d cycles", RUN_CYCLES));
    end

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
// testbench clock source
`default_nettype none

module tb_clk_gen (
    output logic clk_o
);

    // 100 unit period
    initial begin
        clk_o = 1'b0;
        forever begin
            #50 clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/lim_ram_top.sv ====
// logic-in-memory dual-port ram
`default_nettype none

module lim_ram_top import lim_pkg::*; (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    // instruction port
    input  wire logic                  en_a_i,
    input  wire logic [ADDR_WIDTH-1:0] addr_a_i,
    output logic      [DATA_WIDTH-1:0] rdata_a_o,
    // data port
    input  wire logic                  en_b_i,
    input  wire logic                  we_b_i,
    input  wire logic [ADDR_WIDTH-1:0] addr_b_i,
    input  wire logic [DATA_WIDTH-1:0] wdata_b_i,
    input  wire logic [3:0]            be_b_i,
    output logic      [DATA_WIDTH-1:0] rdata_b_o,
    output logic                       rvalid_b_o
);

    lim_funct_t            funct;
    logic                  cfg_access;
    lim_op_e               op_eff;
    logic                  range_active;
    logic [ADDR_WIDTH-1:0] range_end;

    lim_row_if rows ();

    lim_func_cell u_func_cell (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .en_i           (en_b_i),
        .we_i           (we_b_i),
        .addr_i         (addr_b_i),
        .wdata_i        (wdata_b_i),
        .funct_o        (funct),
        .cfg_access_o   (cfg_access),
        .op_eff_o       (op_eff),
        .range_active_o (range_active),
        .range_end_o    (range_end)
    );

    lim_row_decoder u_row_decoder (
        .en_i           (en_b_i),
        .we_i           (we_b_i),
        .addr_i         (addr_b_i),
        .be_i           (be_b_i),
        .wdata_i        (wdata_b_i),
        .cfg_access_i   (cfg_access),
        .op_eff_i       (op_eff),
        .range_active_i (range_active),
        .range_end_i    (range_end),
        .rows           (rows.drv)
    );

    lim_array u_array (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .en_a_i     (en_a_i),
        .addr_a_i   (addr_a_i),
        .rdata_a_o  (rdata_a_o),
        .rvalid_b_o (rvalid_b_o),
        .rdata_b_o  (rdata_b_o),
        .rows       (rows.mem),
        .funct_i    (funct)
    );

endmodule

`default_nettype wire

// ==== hdl/lim_array.sv ====
// byte array with in-memory logic
`default_nettype none

module lim_array import lim_pkg::*; (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  en_a_i,
    input  wire logic [ADDR_WIDTH-1:0] addr_a_i,
    output logic      [DATA_WIDTH-1:0] rdata_a_o,
    output logic                       rvalid_b_o,
    output logic      [DATA_WIDTH-1:0] rdata_b_o,
    lim_row_if.mem                     rows,
    input  wire lim_funct_t            funct_i
);

    localparam logic [WORD_IDX_WIDTH-1:0] FUNCT_WORD = FUNCT_ADDR[ADDR_WIDTH-1:2];

    logic [7:0]            mem [MEM_BYTES];
    logic [ADDR_WIDTH-1:0] a_base;
    logic [ADDR_WIDTH-1:0] b_base;
    logic [DATA_WIDTH-1:0] b_word;
    logic                  logic_op;  // op is one of the six logic codes

    // logic op on one byte, anything else passes the stored byte
    function automatic logic [7:0] op_byte(lim_op_e op, logic [7:0] d, logic [7:0] m);
        case (op)
            OP_AND:  return d & m;
            OP_OR:   return d | m;
            OP_XOR:  return d ^ m;
            OP_NAND: return ~(d & m);
            OP_NOR:  return ~(d | m);
            OP_XNOR: return ~(d ^ m);
            default: return d;
        endcase
    endfunction

    assign logic_op = (rows.op inside {OP_AND, OP_OR, OP_XOR, OP_NAND, OP_NOR, OP_XNOR});

    // ========================================================================
    // write path
    // ========================================================================

    // every enabled byte, one word or a whole range in the same edge
    always_ff @(posedge clk_i) begin
        if (rows.wr) begin
            for (int i = 0; i < MEM_BYTES; i++) begin
                if (rows.row_en[i]) begin
                    if (logic_op) begin
                        mem[i] <= op_byte(rows.op, mem[i],
                                          rows.mask[(i % WORD_BYTES)*8 +: 8]);
                    end else begin
                        mem[i] <= rows.mask[(i % WORD_BYTES)*8 +: 8];  // plain store
                    end
                end
            end
        end
    end

    // ========================================================================
    // read paths
    // ========================================================================

    assign a_base = {addr_a_i[ADDR_WIDTH-1:2], 2'b00};
    assign b_base = {rows.word_idx, 2'b00};

    // cell word replaces the reserved word
    always_comb begin
        if (rows.word_idx == FUNCT_WORD) begin
            b_word = funct_i;
        end else begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                b_word[b*8 +: 8] = mem[b_base + ADDR_WIDTH'(b)];
            end
        end
    end

    // instruction fetch
    always_ff @(posedge clk_i) begin
        if (en_a_i) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                rdata_a_o[b*8 +: 8] <= mem[a_base + ADDR_WIDTH'(b)];
            end
        end
    end

    // data load, held until the next one
    always_ff @(posedge clk_i) begin
        if (rows.rd) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                rdata_b_o[b*8 +: 8] <= op_byte(rows.op, b_word[b*8 +: 8], rows.mask[b*8 +: 8]);
            end
        end
    end

    // one pulse per request, loads and stores alike
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_b_o <= 1'b0;
        end else begin
            rvalid_b_o <= rows.req;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/lim_row_decoder.sv ====
// row enable decoder
`default_nettype none

module lim_row_decoder import lim_pkg::*; (
    input  wire logic                  en_i,
    input  wire logic                  we_i,
    input  wire logic [ADDR_WIDTH-1:0] addr_i,
    input  wire logic [3:0]            be_i,
    input  wire logic [DATA_WIDTH-1:0] wdata_i,
    input  wire logic                  cfg_access_i,
    input  wire lim_op_e               op_eff_i,
    input  wire logic                  range_active_i,
    input  wire logic [ADDR_WIDTH-1:0] range_end_i,
    lim_row_if.drv                     rows
);

    logic [WORD_IDX_WIDTH-1:0] word_idx;
    logic [MEM_WORDS-1:0]      start_dec;  // start marker, one hot
    logic [MEM_WORDS-1:0]      end_dec;    // end marker, only in a range
    logic [MEM_WORDS-1:0]      marker;
    logic [MEM_WORDS-1:0]      word_on;
    logic [MEM_BYTES-1:0]      row_en;

    assign word_idx = addr_i[ADDR_WIDTH-1:2];

    // ========================================================================
    // start and end markers
    // ========================================================================

    always_comb begin
        for (int w = 0; w < MEM_WORDS; w++) begin
            start_dec[w] = (word_idx == WORD_IDX_WIDTH'(w));
            end_dec[w]   = range_active_i && (range_end_i == ADDR_WIDTH'(w));
        end
    end

    assign marker = start_dec ^ end_dec;

    // toggles on at the start word, off again at the end word
    always_comb begin
        word_on[0] = marker[0];
        for (int w = 1; w < MEM_WORDS; w++) begin
            word_on[w] = marker[w] ^ word_on[w-1];
        end
    end

    // ========================================================================
    // byte enables
    // ========================================================================

    always_comb begin
        for (int w = 0; w < MEM_WORDS; w++) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (range_active_i) begin
                    row_en[w*WORD_BYTES + b] = word_on[w];  // whole words in a range
                end else begin
                    row_en[w*WORD_BYTES + b] = start_dec[w] && be_i[b];
                end
            end
        end
    end

    assign rows.req      = en_i;
    assign rows.wr       = en_i && we_i && !cfg_access_i;
    // cell loads go through, the array swaps in the cell word
    assign rows.rd       = en_i && !we_i;
    assign rows.row_en   = row_en;
    assign rows.word_idx = word_idx;
    assign rows.op       = op_eff_i;
    assign rows.mask     = wdata_i;

endmodule

`default_nettype wire

// ==== hdl/lim_func_cell.sv ====
// function cell and range decode
`default_nettype none

module lim_func_cell import lim_pkg::*; (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  en_i,
    input  wire logic                  we_i,
    input  wire logic [ADDR_WIDTH-1:0] addr_i,
    input  wire logic [DATA_WIDTH-1:0] wdata_i,
    output lim_funct_t                 funct_o,
    output logic                       cfg_access_o,
    output lim_op_e                    op_eff_o,
    output logic                       range_active_o,
    output logic [ADDR_WIDTH-1:0]      range_end_o
);

    localparam logic [WORD_IDX_WIDTH-1:0] FUNCT_WORD = FUNCT_ADDR[ADDR_WIDTH-1:2];

    lim_funct_t                funct_q;
    logic [WORD_IDX_WIDTH-1:0] start_word;
    logic [ADDR_WIDTH-1:0]     size_lo;
    logic [ADDR_WIDTH:0]       end_sum;   // one spare bit for overflow

    assign start_word = addr_i[ADDR_WIDTH-1:2];
    assign size_lo    = funct_q.size[ADDR_WIDTH-1:0];

    assign cfg_access_o = (start_word == FUNCT_WORD);

    // programming store, new value seen from the next cycle on
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            funct_q <= '0;
        end else if (en_i && we_i && cfg_access_o) begin
            funct_q <= lim_funct_t'(wdata_i);
        end
    end

    assign funct_o = funct_q;

    // stale op must not touch a cell access
    assign op_eff_o = cfg_access_o ? OP_NONE : funct_q.op;

    assign range_active_o = en_i && we_i && !cfg_access_o && (size_lo > ADDR_WIDTH'(1));

    // ========================================================================
    // range end, one past the last word
    // ========================================================================

    assign end_sum = (ADDR_WIDTH+1)'(start_word) + (ADDR_WIDTH+1)'(size_lo);

    always_comb begin
        if (end_sum > (ADDR_WIDTH+1)'(FUNCT_WORD)) begin
            range_end_o = ADDR_WIDTH'(FUNCT_WORD);  // stop below the cell
        end else begin
            range_end_o = end_sum[ADDR_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/lim_row_if.sv ====
// row command bundle
`default_nettype none

interface lim_row_if import lim_pkg::*; ();

    logic                      req;       // any accepted port b request
    logic                      wr;        // write strobe
    logic                      rd;        // read strobe
    logic [MEM_BYTES-1:0]      row_en;    // one enable per byte
    logic [WORD_IDX_WIDTH-1:0] word_idx;  // read word
    lim_op_e                   op;
    logic [DATA_WIDTH-1:0]     mask;      // write data doubles as mask

    // decoder side
    modport drv (
        output req, wr, rd, row_en, word_idx, op, mask
    );

    // array side
    modport mem (
        input req, wr, rd, row_en, word_idx, op, mask
    );

endinterface

`default_nettype wire

// ==== hdl/lim_pkg.sv ====
// logic-in-memory ram definitions
`default_nettype none

package lim_pkg;

    // ========================================================================
    // sizes
    // ========================================================================

    localparam int ADDR_WIDTH     = 12;               // byte address
    localparam int MEM_BYTES      = 4096;
    localparam int WORD_BYTES     = 4;
    localparam int MEM_WORDS      = MEM_BYTES / WORD_BYTES;
    localparam int DATA_WIDTH     = 32;
    localparam int WORD_IDX_WIDTH = ADDR_WIDTH - 2;   // word index, byte offset dropped
    localparam int SIZE_WIDTH     = 24;

    // last word of the array, holds the function cell
    localparam logic [ADDR_WIDTH-1:0] FUNCT_ADDR = 12'hFFC;

    // ========================================================================
    // operation codes
    // ========================================================================

    // unlisted codes act as a plain load or store
    typedef enum logic [7:0] {
        OP_NONE = 8'd0,
        OP_AND  = 8'd1,
        OP_OR   = 8'd2,
        OP_XOR  = 8'd3,
        OP_NAND = 8'd4,
        OP_NOR  = 8'd5,
        OP_XNOR = 8'd6
    } lim_op_e;

    // function cell word
    // size counts words, 0 and 1 both mean a single access
    typedef struct packed {
        logic [SIZE_WIDTH-1:0] size;
        lim_op_e               op;
    } lim_funct_t;

endpackage

`default_nettype wire
